// File: hdl/mem_stage_macros.svh
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Register and data path width
`define MS_XLEN 64

// Destination register number width
`define MS_REGNO_W 5

// Opcode mnemonic, twelve ASCII characters
`define MS_NAME_W 96

// Byte offset inside one doubleword
`define MS_OFFS_W 3

`endif

// File: hdl/mem_stage_pkg.sv
`include "mem_stage_macros.svh"

package mem_stage_pkg;

  // Memory operation decoded from the mnemonic
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lbu  = 4'd2,
    op_lh   = 4'd3,
    op_lhu  = 4'd4,
    op_lw   = 4'd5,
    op_lwu  = 4'd6,
    op_ld   = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_t;

  // Fields that travel with the instruction down the pipe
  typedef struct packed {
    logic [`MS_XLEN-1:0]    alu_result;   // Address for loads and stores
    logic [`MS_XLEN-1:0]    rs2_value;    // Store value
    logic [`MS_XLEN-1:0]    pc_target;
    logic [`MS_REGNO_W-1:0] rd_regno;
    logic                   load_bool;
    logic                   update_rd_bool;
    logic [`MS_NAME_W-1:0]  opcode_name;
  } inst_fields_t;

  // One doubleword seen as a whole or as its lanes
  typedef union packed {
    logic [`MS_XLEN-1:0] dword;
    logic [7:0][7:0]     bytes;
    logic [3:0][15:0]    halves;
    logic [1:0][31:0]    words;
  } mem_word_u;

endpackage

// File: hdl/mem_op_decode.sv
`timescale 1ns/1ps
`include "mem_stage_macros.svh"

module mem_op_decode (
  input  logic [`MS_NAME_W-1:0] opcode_name,
  output mem_stage_pkg::mem_op_t op
);

  import mem_stage_pkg::*;

  // Mnemonics are right aligned ASCII, zero filled on the left
  always_comb begin
    case (opcode_name)
      "lb": begin
        op = op_lb;
      end
      "lbu": begin
        op = op_lbu;
      end
      "lh": begin
        op = op_lh;
      end
      "lhu": begin
        op = op_lhu;
      end
      "lw": begin
        op = op_lw;
      end
      "lwu": begin
        op = op_lwu;
      end
      "ld": begin
        op = op_ld;
      end
      "sb": begin
        op = op_sb;
      end
      "sh": begin
        op = op_sh;
      end
      "sw": begin
        op = op_sw;
      end
      "sd": begin
        op = op_sd;
      end
      default: begin
        op = op_none;  // ALU, branch, syscall and so on
      end
    endcase
  end

endmodule

// File: hdl/mem_stage_ctrl.sv
`timescale 1ns/1ps

module mem_stage_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  logic                   syscall_flush,
  input  mem_stage_pkg::mem_op_t op,
  input  logic                   mem_ack,
  output logic                   mem_req,
  output logic                   ready,
  output logic                   advance
);

  import mem_stage_pkg::*;

  logic is_mem;
  logic waiting;         // Wait state, a request is outstanding
  logic cancel_pending;  // Flushed request whose ack may still come

  assign is_mem = (op != op_none);

  // Only from idle, and never in an ack cycle
  assign mem_req = in_valid && is_mem && !syscall_flush && !waiting && !mem_ack;

  // Memory ops complete only on their own ack
  assign ready = syscall_flush || !is_mem || (waiting && mem_ack);

  assign advance = in_valid && ready && !syscall_flush;

  always_ff @(posedge clk) begin
    if (reset) begin
      waiting <= 1'b0;
    end else if (syscall_flush) begin
      waiting <= 1'b0;  // Abandon the request
    end else if (mem_req) begin
      waiting <= 1'b1;
    end else if (waiting && mem_ack) begin
      waiting <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cancel_pending <= 1'b0;
    end else if (waiting && syscall_flush && !mem_ack) begin
      cancel_pending <= 1'b1;
    end else if (mem_ack) begin
      cancel_pending <= 1'b0;
    end
  end

  a_no_req_in_wait: assert property (
    @(posedge clk) disable iff (reset) mem_req |=> waiting && !mem_req
  ) else $error("request did not move to wait as a single pulse");

  // Memory only answers requests, so an idle ack must be a cancelled one
  a_no_stray_ack: assert property (
    @(posedge clk) disable iff (reset) (mem_ack && !waiting) |-> cancel_pending
  ) else $error("mem_ack while idle without a cancelled request");

  a_flush_idle: assert property (
    @(posedge clk) disable iff (reset) syscall_flush |=> !waiting
  ) else $error("controller not idle after flush");

endmodule

// File: hdl/load_align.sv
`timescale 1ns/1ps
`include "mem_stage_macros.svh"

module load_align (
  input  mem_stage_pkg::mem_op_t   op,
  input  logic [`MS_OFFS_W-1:0]    offset,
  input  mem_stage_pkg::mem_word_u rdata,
  output logic [`MS_XLEN-1:0]      load_value
);

  import mem_stage_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  logic [31:0] sel_word;

  // Low offset bits below the access size are ignored
  assign sel_byte = rdata.bytes[offset];
  assign sel_half = rdata.halves[offset[2:1]];
  assign sel_word = rdata.words[offset[2]];

  always_comb begin
    case (op)
      op_lb: begin
        load_value = {{(`MS_XLEN-8){sel_byte[7]}}, sel_byte};
      end
      op_lbu: begin
        load_value = {{(`MS_XLEN-8){1'b0}}, sel_byte};
      end
      op_lh: begin
        load_value = {{(`MS_XLEN-16){sel_half[15]}}, sel_half};
      end
      op_lhu: begin
        load_value = {{(`MS_XLEN-16){1'b0}}, sel_half};
      end
      op_lw: begin
        load_value = {{(`MS_XLEN-32){sel_word[31]}}, sel_word};
      end
      op_lwu: begin
        load_value = {{(`MS_XLEN-32){1'b0}}, sel_word};
      end
      op_ld: begin
        load_value = rdata.dword;
      end
      default: begin
        load_value = '0;  // Stores and non-memory ops
      end
    endcase
  end

  // Checked after the decode chain settles
  always_comb begin
    a_half_align: assert final (!(op inside {op_lh, op_lhu}) || (offset[0] == 1'b0))
      else $error("halfword load at odd offset %0d", offset);
    a_word_align: assert final (!(op inside {op_lw, op_lwu}) || (offset[1:0] == 2'b00))
      else $error("word load at unaligned offset %0d", offset);
  end

endmodule

// File: hdl/stage_regs.sv
`timescale 1ns/1ps
`include "mem_stage_macros.svh"

module stage_regs (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        advance,
  input  logic                        syscall_flush,
  input  logic                        is_store,
  input  logic                        is_load,
  input  mem_stage_pkg::inst_fields_t inst,
  input  logic [`MS_XLEN-1:0]         load_value,
  input  logic [`MS_XLEN-1:0]         store_addr,
  output logic                        out_valid,
  output mem_stage_pkg::inst_fields_t out_inst,
  output logic [`MS_XLEN-1:0]         mdata,
  output logic [`MS_XLEN-1:0]         phy_addr
);

  always_ff @(posedge clk) begin
    if (reset || syscall_flush) begin
      out_valid <= 1'b0;
      out_inst  <= '0;
      mdata     <= '0;
      phy_addr  <= '0;
    end else if (advance) begin
      out_valid <= 1'b1;
      out_inst  <= inst;
      if (is_load) begin
        mdata <= load_value;
      end else begin
        mdata <= '0;
      end
      if (is_store) begin
        phy_addr <= store_addr;  // No translation, aligned VA
      end else begin
        phy_addr <= '0;
      end
    end else begin
      out_valid <= 1'b0;  // Bubble, payload held
    end
  end

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`include "mem_stage_macros.svh"

module mem_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_valid,
  input  logic                        syscall_flush,
  input  mem_stage_pkg::inst_fields_t inst,
  output logic                        ready,
  output logic                        mem_req,
  output logic [`MS_XLEN-1:0]         mem_addr,
  output logic                        mem_is_store,
  input  logic                        mem_ack,
  input  logic [`MS_XLEN-1:0]         mem_rdata,
  output logic                        out_valid,
  output mem_stage_pkg::inst_fields_t out_inst,
  output logic [`MS_XLEN-1:0]         mdata,
  output logic [`MS_XLEN-1:0]         phy_addr
);

  import mem_stage_pkg::*;

  mem_op_t              op;
  logic                 advance;
  logic                 is_load;
  logic                 is_store;
  logic [`MS_XLEN-1:0]  load_value;

  assign is_load  = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  assign is_store = op inside {op_sb, op_sh, op_sw, op_sd};

  // Doubleword that holds the access
  assign mem_addr     = {inst.alu_result[`MS_XLEN-1:`MS_OFFS_W], {`MS_OFFS_W{1'b0}}};
  assign mem_is_store = is_store;

  mem_op_decode u_decode (
    .opcode_name (inst.opcode_name),
    .op          (op)
  );

  mem_stage_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .syscall_flush (syscall_flush),
    .op            (op),
    .mem_ack       (mem_ack),
    .mem_req       (mem_req),
    .ready         (ready),
    .advance       (advance)
  );

  load_align u_align (
    .op         (op),
    .offset     (inst.alu_result[`MS_OFFS_W-1:0]),
    .rdata      (mem_rdata),
    .load_value (load_value)
  );

  stage_regs u_regs (
    .clk           (clk),
    .reset         (reset),
    .advance       (advance),
    .syscall_flush (syscall_flush),
    .is_store      (is_store),
    .is_load       (is_load),
    .inst          (inst),
    .load_value    (load_value),
    .store_addr    (mem_addr),
    .out_valid     (out_valid),
    .out_inst      (out_inst),
    .mdata         (mdata),
    .phy_addr      (phy_addr)
  );

endmodule

// File: verif/tb_mem_stage.sv
`timescale 1ns/1ps
`include "mem_stage_macros.svh"

module tb_mem_stage;

  import mem_stage_pkg::*;

  typedef struct packed {
    inst_fields_t        inst;
    logic [`MS_XLEN-1:0] mdata;
    logic [`MS_XLEN-1:0] phy_addr;
  } beat_t;

  localparam int timeout_cycles = 40;
  localparam int kind_none  = 0;
  localparam int kind_load  = 1;
  localparam int kind_store = 2;

  localparam logic [`MS_NAME_W-1:0] load_names [0:6] = '{
    "lb", "lbu", "lh", "lhu", "lw", "lwu", "ld"
  };
  localparam logic [`MS_NAME_W-1:0] store_names [0:3] = '{"sb", "sh", "sw", "sd"};
  localparam logic [`MS_NAME_W-1:0] other_names [0:7] = '{
    "add", "addi", "sub", "beq", "jal", "lui", "syscall", "auipc"
  };

  logic                clk;
  logic                reset;
  logic                in_valid;
  logic                syscall_flush;
  inst_fields_t        inst;
  logic                ready;
  logic                mem_req;
  logic [`MS_XLEN-1:0] mem_addr;
  logic                mem_is_store;
  logic                mem_ack;
  logic [`MS_XLEN-1:0] mem_rdata;
  logic                out_valid;
  inst_fields_t        out_inst;
  logic [`MS_XLEN-1:0] mdata;
  logic [`MS_XLEN-1:0] phy_addr;

  integer seed = 32'h43a14641;
  logic   long_ack;        // Forces the slowest memory answer
  beat_t  expected_q[$];

  mem_stage i_dut (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .syscall_flush (syscall_flush),
    .inst          (inst),
    .ready         (ready),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .mem_is_store  (mem_is_store),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .out_valid     (out_valid),
    .out_inst      (out_inst),
    .mdata         (mdata),
    .phy_addr      (phy_addr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic mismatch(input string sig, input string expected, input string actual);
    abort_run($sformatf("%s expected %s actual %s", sig, expected, actual));
  endtask

  // Memory contents, a fixed function of the doubleword address
  function automatic logic [63:0] scramble(input logic [63:0] a);
    return (a * 64'h9e3779b97f4a7c15) ^ {a[31:0], a[63:32]} ^ 64'hc3a50f965a3ce187;
  endfunction

  function automatic int access_kind(input logic [`MS_NAME_W-1:0] name);
    case (name)
      "lb", "lbu", "lh", "lhu", "lw", "lwu", "ld": return kind_load;
      "sb", "sh", "sw", "sd": return kind_store;
      default: return kind_none;
    endcase
  endfunction

  // Natural alignment of the access size
  function automatic logic [2:0] offset_mask(input logic [`MS_NAME_W-1:0] name);
    case (name)
      "lh", "lhu", "sh": return 3'b110;
      "lw", "lwu", "sw": return 3'b100;
      "ld", "sd": return 3'b000;
      default: return 3'b111;
    endcase
  endfunction

  function automatic inst_fields_t make_inst(input logic [`MS_NAME_W-1:0] name);
    inst_fields_t f;
    logic [31:0]  r;
    f.alu_result = {$random(seed), $random(seed)};
    f.alu_result[2:0] = f.alu_result[2:0] & offset_mask(name);
    f.rs2_value = {$random(seed), $random(seed)};
    f.pc_target = {$random(seed), $random(seed)};
    r = $random(seed);
    f.rd_regno = r[4:0];
    f.load_bool = (access_kind(name) == kind_load);
    f.update_rd_bool = r[5];
    f.opcode_name = name;
    return f;
  endfunction

  // Expected output beat from the RISC-V load and store rules
  function automatic beat_t expected_beat(input inst_fields_t f, input logic [63:0] word);
    beat_t       b;
    logic [63:0] lane;
    lane = word >> {f.alu_result[2:0], 3'b000};
    b.inst = f;
    b.mdata = '0;
    b.phy_addr = '0;
    case (f.opcode_name)
      "lb": b.mdata = {{56{lane[7]}}, lane[7:0]};
      "lbu": b.mdata = {56'd0, lane[7:0]};
      "lh": b.mdata = {{48{lane[15]}}, lane[15:0]};
      "lhu": b.mdata = {48'd0, lane[15:0]};
      "lw": b.mdata = {{32{lane[31]}}, lane[31:0]};
      "lwu": b.mdata = {32'd0, lane[31:0]};
      "ld": b.mdata = word;
      "sb", "sh", "sw", "sd": b.phy_addr = {f.alu_result[63:3], 3'b000};
      default: b.mdata = '0;
    endcase
    return b;
  endfunction

  task automatic check_zero_outputs();
    assert (mem_req == 1'b0) else mismatch("mem_req", "0", $sformatf("%0b", mem_req));
    assert (out_valid == 1'b0) else mismatch("out_valid", "0", $sformatf("%0b", out_valid));
    assert (out_inst == '0) else mismatch("out_inst", "0", $sformatf("%0h", out_inst));
    assert (mdata == '0) else mismatch("mdata", "0", $sformatf("%0h", mdata));
    assert (phy_addr == '0) else mismatch("phy_addr", "0", $sformatf("%0h", phy_addr));
  endtask

  // Starts and ends on a falling edge
  task automatic issue(input logic [`MS_NAME_W-1:0] name);
    inst_fields_t f;
    logic [31:0]  r;
    logic [63:0]  line_addr;
    int           kind;
    int           cycles;
    int           reqs;
    logic         accepted;
    f = make_inst(name);
    kind = access_kind(name);
    line_addr = {f.alu_result[63:3], 3'b000};
    inst = f;
    in_valid = 1'b1;
    cycles = 0;
    reqs = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      if (mem_req) begin
        reqs++;
        assert (mem_addr == line_addr)
          else mismatch("mem_addr", $sformatf("%0h", line_addr), $sformatf("%0h", mem_addr));
        assert (mem_is_store == (kind == kind_store))
          else mismatch("mem_is_store", $sformatf("%0b", kind == kind_store),
                        $sformatf("%0b", mem_is_store));
      end
      if (cycles == 0) begin
        // No request rises in an ack cycle
        assert (mem_req == ((kind != kind_none) && !mem_ack))
          else abort_run("mem_req wrong in the first cycle of an instruction");
        assert (ready == (kind == kind_none))
          else mismatch("ready", $sformatf("%0b", kind == kind_none), $sformatf("%0b", ready));
      end
      if (ready) begin
        accepted = 1'b1;
      end else begin
        cycles++;
        if (cycles > timeout_cycles) begin
          abort_run("instruction not accepted before the timeout");
        end
      end
    end
    if (kind != kind_none) begin
      assert (mem_ack) else abort_run("memory op accepted without mem_ack");
    end
    assert (reqs == ((kind != kind_none) ? 1 : 0))
      else abort_run($sformatf("%0d memory requests for one instruction", reqs));
    expected_q.push_back(expected_beat(f, scramble(line_addr)));
    @(negedge clk);
    in_valid = 1'b0;
    r = $random(seed);
    if (r[0]) begin
      @(negedge clk);  // Idle gap
    end
  endtask

  task automatic flush_waiting_load();
    inst_fields_t f;
    f = make_inst("ld");
    long_ack = 1'b1;
    inst = f;
    in_valid = 1'b1;
    @(posedge clk);
    assert (mem_req) else abort_run("load before flush raised no request");
    @(negedge clk);
    syscall_flush = 1'b1;
    @(posedge clk);
    assert (ready) else mismatch("ready", "1", $sformatf("%0b", ready));
    assert (!mem_req) else mismatch("mem_req", "0", $sformatf("%0b", mem_req));
    @(negedge clk);
    syscall_flush = 1'b0;
    in_valid = 1'b0;
    long_ack = 1'b0;
    @(posedge clk);
    check_zero_outputs();
    @(negedge clk);
    @(negedge clk);  // Late ack rises here, together with the next instruction
  endtask

  // One request at a time, answered after 0 to 3 idle cycles
  initial begin : memory_responder
    logic [63:0] addr;
    logic [31:0] r;
    int          delay;
    forever begin
      @(posedge clk);
      if (!reset && mem_req) begin
        addr = mem_addr;
        r = $random(seed);
        delay = long_ack ? 3 : (r & 32'd3);
        @(negedge clk);
        repeat (delay) @(negedge clk);
        mem_rdata = scramble(addr);
        mem_ack = 1'b1;
        @(negedge clk);
        mem_ack = 1'b0;
        mem_rdata = '0;
      end
    end
  end

  initial begin : compare_outputs
    beat_t exp;
    forever begin
      @(posedge clk);
      if (!reset && out_valid) begin
        if (expected_q.size() == 0) begin
          abort_run("output beat without an accepted instruction");
        end else begin
          exp = expected_q.pop_front();
          assert (out_inst == exp.inst)
            else mismatch("out_inst", $sformatf("%0h", exp.inst), $sformatf("%0h", out_inst));
          assert (mdata == exp.mdata)
            else mismatch("mdata", $sformatf("%0h", exp.mdata), $sformatf("%0h", mdata));
          assert (phy_addr == exp.phy_addr)
            else mismatch("phy_addr", $sformatf("%0h", exp.phy_addr), $sformatf("%0h", phy_addr));
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] k;
    int          i;
    int          cycles;
    reset = 1'b1;
    in_valid = 1'b0;
    syscall_flush = 1'b0;
    inst = '0;
    mem_ack = 1'b0;
    mem_rdata = '0;
    long_ack = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_zero_outputs();
    reset = 1'b0;
    @(negedge clk);
    check_zero_outputs();

    for (i = 0; i < 40; i++) begin
      r = $random(seed);
      issue(load_names[r % 7]);
    end
    for (i = 0; i < 24; i++) begin
      r = $random(seed);
      issue(store_names[r % 4]);
    end
    for (i = 0; i < 12; i++) begin
      r = $random(seed);
      issue(other_names[r % 8]);
    end
    for (i = 0; i < 3; i++) begin
      flush_waiting_load();
      r = $random(seed);
      issue(load_names[r % 7]);  // Must not see the late ack
    end
    for (i = 0; i < 60; i++) begin
      r = $random(seed);
      k = $random(seed);
      case (r % 3)
        0: issue(load_names[k % 7]);
        1: issue(store_names[k % 4]);
        default: issue(other_names[k % 8]);
      endcase
    end

    cycles = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_cycles) begin
        abort_run("output beats missing at the end of the run");
      end
    end
    repeat (4) @(negedge clk);  // Room for stray beats
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: mem_stage.f
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/mem_op_decode.sv
hdl/mem_stage_ctrl.sv
hdl/load_align.sv
hdl/stage_regs.sv
hdl/mem_stage.sv
verif/tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_stage -f mem_stage.f

out=$(./obj_dir/Vtb_mem_stage 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'; then
  exit 0
fi
exit 1
